/* files.f */
+incdir+include
hw/balance_pkg.sv
hw/pd_math.sv
hw/i_term.sv
hw/motor_mix.sv
hw/pwm_out.sv
hw/balance_ctrl.sv
testbench/balance_ctrl_asserts.sv
testbench/balance_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the balance controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module balance_ctrl_tb -f files.f -o balance_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $build_status"
	exit 1
fi

# Let assertion errors be counted instead of stopping at the first one
./obj_dir/balance_sim +verilator+error+limit+100 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test passed" "$SIM_LOG"; then
	exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

/* testbench/balance_ctrl_tb.sv */
`timescale 1ns/1ps
`include "balance_settings.svh"

module balance_ctrl_tb;

	import balance_pkg::*;

	localparam int DEPTH   = `D_QUEUE_DEPTH;
	localparam int MAG_CAP = (1 << `PWM_WIDTH) - 1;

	logic          clk = 1'b0;
	logic          rst_n;
	logic          vld;
	pitch_sample_t sample;
	motor_cmd_t    cmd;
	logic          cmd_vld;
	logic          pwm_lft;
	logic          pwm_rght;
	logic          dir_lft;
	logic          dir_rght;

	int         hist [DEPTH];   // Model copy of past clamped errors, [0] newest
	int         integ;          // Model integrator
	motor_cmd_t exp_q [$];      // Expected commands in strobe order
	motor_cmd_t last_exp;
	int         mismatch_count = 0;
	int         other_count = 0;
	bit         timed_out = 1'b0;

	always #20 clk = ~clk; // 40 ns period

	balance_ctrl uut (.*);

	function automatic int clamp(input int v, input int lo, input int hi);
		return (v > hi) ? hi : ((v < lo) ? lo : v);
	endfunction

	// Keep the low 10 bits as a signed value
	function automatic int wrap10(input int v);
		logic signed [9:0] w;
		w = 10'(v);
		return int'(w);
	endfunction

	//////////////////////////////////////////////////
	// Reference model, one call per strobe
	//////////////////////////////////////////////////
	function automatic void model_step(input pitch_sample_t s);
		int err;
		int e_sat;
		int p;
		int d;
		int sum;
		int st;
		int k;
		motor_cmd_t c;
		err   = int'($signed(s.actual)) - int'($signed(s.desired));
		e_sat = clamp(err, -512, 511);
		p     = (e_sat >>> 1) + (e_sat >>> 3);                     // 5/8 gain
		d     = clamp(wrap10(e_sat - hist[DEPTH-1]), -64, 63) * `DTERM_GAIN;
		for (k = DEPTH - 1; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = e_sat;
		integ   = clamp(integ + e_sat, -32768, 32767);
		sum     = clamp(p + (integ >>> `ITERM_SHIFT) + d, -2048, 2047);
		st      = int'($signed(s.steer));
		c.lft   = 12'(clamp(sum + st, -2048, 2047));
		c.rght  = 12'(clamp(sum - st, -2048, 2047));
		exp_q.push_back(c);
		last_exp = c;
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	// Every cmd_vld consumes the oldest expected command
	always @(negedge clk) begin : compare_cmd
		motor_cmd_t exp_cmd;
		if (cmd_vld) begin
			if (exp_q.size() == 0) begin
				$display("ERROR t=%0t cmd_vld pulsed with no command expected", $time);
				other_count++;
			end else begin
				exp_cmd = exp_q.pop_front();
				check_value("cmd.lft", int'($signed(cmd.lft)), int'($signed(exp_cmd.lft)));
				check_value("cmd.rght", int'($signed(cmd.rght)), int'($signed(exp_cmd.rght)));
			end
		end
	end

	function automatic int rand_span(input int span);
		return int'($urandom_range(2 * span)) - span; // Uniform in [-span, span]
	endfunction

	// Random pitch offset so only the difference matters
	function automatic pitch_sample_t make_sample(input int err, input int steer);
		pitch_sample_t s;
		int base;
		base      = int'($urandom_range(20000)) - 10000;
		s.desired = 16'(base);
		s.actual  = 16'(base + err);
		s.steer   = 11'(steer); // 1024 wraps to -1024
		return s;
	endfunction

	task automatic drive_strobe(input pitch_sample_t s);
		@(posedge clk);
		vld    <= 1'b1;
		sample <= s;
		model_step(s);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			vld <= 1'b0;
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("TIMEOUT t=%0t %0d expected commands never arrived", $time, exp_q.size());
			other_count++;
			timed_out = 1'b1;
		end
	endtask

	// Outputs must sit at their reset values
	task automatic check_idle(input int n);
		repeat (n) begin
			@(negedge clk);
			check_value("cmd.lft", int'($signed(cmd.lft)), 0);
			check_value("cmd.rght", int'($signed(cmd.rght)), 0);
			check_value("pwm_lft", int'(pwm_lft), 0);
			check_value("pwm_rght", int'(pwm_rght), 0);
			check_value("dir_lft", int'(dir_lft), 0);
			check_value("dir_rght", int'(dir_rght), 0);
		end
	endtask

	// Gap 0 gives strobes on consecutive cycles
	task automatic run_strobes(input int count, input int err_base, input int err_span,
		input int steer_span, input int max_gap);
		if (timed_out)
			return;
		repeat (count) begin
			drive_strobe(make_sample(err_base + rand_span(err_span), rand_span(steer_span)));
			if (max_gap > 0)
				idle(int'($urandom_range(max_gap, 1)));
		end
		idle(1);
		wait_drain(40);
	endtask

	function automatic int pwm_mag(input logic signed [11:0] v);
		int a;
		a = int'(v);
		a = (a < 0) ? -a : a;
		return (a > MAG_CAP) ? MAG_CAP : a;
	endfunction

	//////////////////////////////////////////////////
	// Duty cycle over one full counter period
	//////////////////////////////////////////////////
	task automatic pwm_check(input pitch_sample_t s);
		int n;
		int hi_l;
		int hi_r;
		if (timed_out)
			return;
		drive_strobe(s);
		idle(1);
		n = 0;
		while (!cmd_vld && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (!cmd_vld) begin
			$display("TIMEOUT t=%0t no cmd_vld within 10 cycles of a strobe", $time);
			other_count++;
			timed_out = 1'b1;
			return;
		end
		@(posedge clk); // Duty loads here
		hi_l = 0;
		hi_r = 0;
		repeat (1 << `PWM_WIDTH) begin
			@(negedge clk);
			if (pwm_lft)
				hi_l++;
			if (pwm_rght)
				hi_r++;
		end
		check_value("pwm_lft high cycles", hi_l, pwm_mag(last_exp.lft));
		check_value("pwm_rght high cycles", hi_r, pwm_mag(last_exp.rght));
		check_value("dir_lft", int'(dir_lft), int'($signed(last_exp.lft) < 0));
		check_value("dir_rght", int'(dir_rght), int'($signed(last_exp.rght) < 0));
	endtask

	initial begin
		void'($urandom(32'h2abb));
		rst_n  = 1'b0;
		vld    = 1'b0;
		sample = '0;
		integ  = 0;
		foreach (hist[k])
			hist[k] = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		check_idle(100);
		run_strobes(40, 0, 400, 100, 4);    // Small errors, spans the 12 deep queue
		run_strobes(40, 0, 20000, 300, 3);  // Error, derivative and sum clamps
		run_strobes(300, 300, 0, 0, 1);     // Integrator windup to the ceiling
		run_strobes(60, 0, 20000, 1024, 0); // Back to back, steering clamp
		repeat (4)
			pwm_check(make_sample(rand_span(3000), rand_span(1024)));
		$display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, other_count, uut.u_asserts.fail_count);
		if (mismatch_count + other_count + uut.u_asserts.fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* testbench/balance_ctrl_asserts.sv */
`timescale 1ns/1ps
`include "balance_settings.svh"

module balance_ctrl_asserts (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  vld,
	input logic                  cmd_vld,
	input logic                  pwm_lft,
	input logic                  pwm_rght,
	input logic [`PWM_WIDTH-1:0] mag_lft,  // Loaded duty inside pwm_out
	input logic [`PWM_WIDTH-1:0] mag_rght
);

	int fail_count = 0; // Summed into the final report

	// Fixed two cycle latency, both directions
	a_cmd_after_vld: assert property (@(posedge clk) disable iff (!rst_n) vld |-> ##2 cmd_vld)
		else begin
			$error("cmd_vld missing two cycles after vld");
			fail_count++;
		end

	a_cmd_has_vld: assert property (@(posedge clk) disable iff (!rst_n) cmd_vld |-> $past(vld, 2))
		else begin
			$error("cmd_vld without a strobe two cycles earlier");
			fail_count++;
		end

	// Zero duty keeps the pin quiet
	a_lft_zero: assert property (@(posedge clk) disable iff (!rst_n) (mag_lft == '0) |-> !pwm_lft)
		else begin
			$error("pwm_lft high with zero magnitude");
			fail_count++;
		end

	a_rght_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(mag_rght == '0) |-> !pwm_rght)
		else begin
			$error("pwm_rght high with zero magnitude");
			fail_count++;
		end

endmodule

bind balance_ctrl balance_ctrl_asserts u_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.vld      (vld),
	.cmd_vld  (cmd_vld),
	.pwm_lft  (pwm_lft),
	.pwm_rght (pwm_rght),
	.mag_lft  (u_pwm_out.mag_lft),
	.mag_rght (u_pwm_out.mag_rght)
);

/* hw/balance_ctrl.sv */
`timescale 1ns/1ps

module balance_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       vld,      // Sensor strobe
	input  balance_pkg::pitch_sample_t sample,
	output balance_pkg::motor_cmd_t    cmd,
	output logic                       cmd_vld,  // Two cycles after vld
	output logic                       pwm_lft,
	output logic                       pwm_rght,
	output logic                       dir_lft,
	output logic                       dir_rght
);

	import balance_pkg::*;

	pd_terms_t  pd_terms; // Combinational, same cycle as vld
	pid_terms_t pid;      // Registered on vld
	logic       pid_vld;

	//////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////
	pd_math u_pd_math (
		.clk     (clk),
		.rst_n   (rst_n),
		.vld     (vld),
		.desired (sample.desired),
		.actual  (sample.actual),
		.terms   (pd_terms)
	);

	i_term u_i_term (
		.clk     (clk),
		.rst_n   (rst_n),
		.vld     (vld),
		.pd      (pd_terms),
		.steer   (sample.steer),
		.pid     (pid),
		.pid_vld (pid_vld)
	);

	motor_mix u_motor_mix (
		.clk     (clk),
		.rst_n   (rst_n),
		.pid     (pid),
		.pid_vld (pid_vld),
		.cmd     (cmd),
		.cmd_vld (cmd_vld)
	);

	// Duty loads on cmd_vld
	pwm_out u_pwm_out (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd      (cmd),
		.cmd_vld  (cmd_vld),
		.pwm_lft  (pwm_lft),
		.pwm_rght (pwm_rght),
		.dir_lft  (dir_lft),
		.dir_rght (dir_rght)
	);

endmodule

/* hw/pwm_out.sv */
`timescale 1ns/1ps
`include "balance_settings.svh"

module pwm_out (
	input  logic                    clk,
	input  logic                    rst_n,
	input  balance_pkg::motor_cmd_t cmd,
	input  logic                    cmd_vld,
	output logic                    pwm_lft,
	output logic                    pwm_rght,
	output logic                    dir_lft,  // 1 when command negative
	output logic                    dir_rght
);

	localparam logic [11:0] MAG_MAX = 12'((1 << `PWM_WIDTH) - 1);

	logic [`PWM_WIDTH-1:0] cnt;      // Free running, wraps each period
	logic [`PWM_WIDTH-1:0] mag_lft;  // Loaded duty
	logic [`PWM_WIDTH-1:0] mag_rght;

	// Absolute value capped at the counter maximum
	function automatic logic [`PWM_WIDTH-1:0] mag_of(input logic signed [11:0] v);
		logic [11:0] a;
		a = v[11] ? 12'(-v) : 12'(v); // -2048 becomes 2048 unsigned
		if (a > MAG_MAX)
			a = MAG_MAX;
		return a[`PWM_WIDTH-1:0];
	endfunction

	//////////////////////////////////////////////////
	// Counter and duty registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt      <= '0;
			mag_lft  <= '0;
			mag_rght <= '0;
			dir_lft  <= 1'b0;
			dir_rght <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			if (cmd_vld) begin // New duty from the next edge on
				mag_lft  <= mag_of(cmd.lft);
				mag_rght <= mag_of(cmd.rght);
				dir_lft  <= cmd.lft[11];
				dir_rght <= cmd.rght[11];
			end
		end
	end

	assign pwm_lft  = (cnt < mag_lft);  // High mag cycles per period
	assign pwm_rght = (cnt < mag_rght);

endmodule

/* hw/motor_mix.sv */
`timescale 1ns/1ps

module motor_mix (
	input  logic                    clk,
	input  logic                    rst_n,
	input  balance_pkg::pid_terms_t pid,
	input  logic                    pid_vld,
	output balance_pkg::motor_cmd_t cmd,    // Held between strobes
	output logic                    cmd_vld
);

	logic signed [12:0] sum_wide;  // 13 bit headroom for three terms
	logic signed [11:0] sum_sat;
	logic signed [12:0] lft_wide;
	logic signed [12:0] rght_wide;
	logic signed [11:0] lft_sat;
	logic signed [11:0] rght_sat;

	// Clamp a 13 bit value to the 12 bit command range
	function automatic logic signed [11:0] sat12(input logic signed [12:0] v);
		logic signed [11:0] r;
		if (v > 13'sd2047)
			r = 12'sd2047;
		else if (v < -13'sd2048)
			r = -12'sd2048;
		else
			r = v[11:0];
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Term sum and steering mix
	//////////////////////////////////////////////////
	assign sum_wide = 13'(pid.pterm) + 13'(pid.iterm) + 13'(pid.dterm);
	assign sum_sat  = sat12(sum_wide);

	// Each wheel saturates on its own
	assign lft_wide  = 13'(sum_sat) + 13'(pid.steer);
	assign rght_wide = 13'(sum_sat) - 13'(pid.steer);
	assign lft_sat   = sat12(lft_wide);
	assign rght_sat  = sat12(rght_wide);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd     <= '0; // Motors idle out of reset
			cmd_vld <= 1'b0;
		end else begin
			cmd_vld <= pid_vld;
			if (pid_vld) begin
				cmd.lft  <= lft_sat;
				cmd.rght <= rght_sat;
			end
		end
	end

endmodule

/* hw/i_term.sv */
`timescale 1ns/1ps
`include "balance_settings.svh"

module i_term (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   vld,
	input  balance_pkg::pd_terms_t pd,
	input  logic signed [10:0]     steer,
	output balance_pkg::pid_terms_t pid,
	output logic                   pid_vld // One cycle after vld
);

	logic signed [15:0] integ;     // Accumulated error
	logic signed [16:0] integ_sum; // One bit of headroom
	logic signed [15:0] integ_nxt;
	logic signed [15:0] integ_shr;

	assign integ_sum = 17'(integ) + 17'(pd.err_sat);

	// Saturate at the 16 bit rails so windup holds at the ceiling
	always_comb begin
		if (integ_sum > 17'sd32767)
			integ_nxt = 16'sd32767;
		else if (integ_sum < -17'sd32768)
			integ_nxt = -16'sd32768;
		else
			integ_nxt = integ_sum[15:0];
	end

	assign integ_shr = integ_nxt >>> `ITERM_SHIFT; // Updated value, not the old one

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			integ   <= '0;
			pid_vld <= 1'b0;
		end else begin
			pid_vld <= vld;
			if (vld)
				integ <= integ_nxt;
		end
	end

	//////////////////////////////////////////////////
	// Stage boundary, all three terms move together
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (vld) begin
			pid.pterm <= pd.pterm;
			pid.iterm <= integ_shr[9:0];
			pid.dterm <= pd.dterm;
			pid.steer <= steer;
		end
	end

endmodule

/* hw/pd_math.sv */
`timescale 1ns/1ps
`include "balance_settings.svh"

module pd_math (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  vld,     // New reading this cycle
	input  logic [15:0]           desired,
	input  logic [15:0]           actual,
	output balance_pkg::pd_terms_t terms
);

	localparam int DEPTH = `D_QUEUE_DEPTH;
	localparam logic signed [11:0] DGAIN = `DTERM_GAIN;

	logic signed [16:0] err;        // Full-range error
	logic signed [9:0]  err_sat;
	logic signed [9:0]  prev_err [0:DEPTH-1];
	logic signed [9:0]  d_diff;     // Wraps modulo 10 bits
	logic signed [6:0]  d_diff_sat;
	logic signed [11:0] d_ext;

	// Sign-extend both to 17 bits before subtracting
	assign err = $signed({actual[15], actual}) - $signed({desired[15], desired});

	// Clamp error into 10 bit range
	always_comb begin
		if (err > 17'sd511)
			err_sat = 10'sd511;
		else if (err < -17'sd512)
			err_sat = -10'sd512;
		else
			err_sat = err[9:0];
	end

	assign terms.err_sat = err_sat;
	assign terms.pterm   = (err_sat >>> 1) + (err_sat >>> 3); // 1/2 + 1/8

	//////////////////////////////////////////////////
	// Derivative history queue
	//////////////////////////////////////////////////
	for (genvar i = 0; i < DEPTH; i++) begin : g_queue
		if (i == 0) begin : g_head
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n)
					prev_err[i] <= '0;
				else if (vld)
					prev_err[i] <= err_sat;     // Newest at head
			end
		end else begin : g_tail
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n)
					prev_err[i] <= '0;
				else if (vld)
					prev_err[i] <= prev_err[i-1];
			end
		end
	end

	// Current minus value from DEPTH strobes back
	assign d_diff = err_sat - prev_err[DEPTH-1];

	// Clamp to 7 bits signed
	always_comb begin
		if (d_diff > 10'sd63)
			d_diff_sat = 7'sd63;
		else if (d_diff < -10'sd64)
			d_diff_sat = -7'sd64;
		else
			d_diff_sat = d_diff[6:0];
	end

	assign d_ext       = 12'(d_diff_sat); // Sign-extended
	assign terms.dterm = d_ext * DGAIN;   // Fits in 12 bits, |448| max

endmodule

/* hw/balance_pkg.sv */
package balance_pkg;

	//////////////////////////////////////////////////
	// Sensor side
	//////////////////////////////////////////////////

	// One sensor reading, valid with the vld strobe
	typedef struct packed {
		logic        [15:0] desired; // Target pitch
		logic        [15:0] actual;  // Measured pitch
		logic signed [10:0] steer;   // Steering offset, + turns right wheel slower
	} pitch_sample_t;

	//////////////////////////////////////////////////
	// Between stages
	//////////////////////////////////////////////////

	// Combinational output of pd_math
	typedef struct packed {
		logic signed [9:0]  err_sat; // Clamped error, reused by integrator
		logic signed [9:0]  pterm;   // 5/8 of err_sat
		logic signed [11:0] dterm;   // Clamped difference times gain
	} pd_terms_t;

	// Registered output of i_term
	typedef struct packed {
		logic signed [9:0]  pterm;
		logic signed [9:0]  iterm;
		logic signed [11:0] dterm;
		logic signed [10:0] steer; // Carried along with its reading
	} pid_terms_t;

	// Signed wheel commands
	typedef struct packed {
		logic signed [11:0] lft;
		logic signed [11:0] rght;
	} motor_cmd_t;

endpackage

/* include/balance_settings.svh */
`ifndef BALANCE_SETTINGS_SVH
`define BALANCE_SETTINGS_SVH

//////////////////////////////////////////////////
// Balance controller fixed tuning
//////////////////////////////////////////////////

// Past saturated errors held for the derivative
`define D_QUEUE_DEPTH 12

// Derivative multiplier applied to clamped D_diff
`define DTERM_GAIN 7

// Integrator right shift giving the integral term
`define ITERM_SHIFT 6

// Free-running PWM counter width, period is 2**PWM_WIDTH
`define PWM_WIDTH 11

`endif
